// File: hdl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// address of the first fetch after reset.
`define RV_RESET_PC 32'h0000_1000

// next pc after any bus error response.
`define RV_TRAP_PC 32'h0000_0000

// integer register count.
`define RV_NREGS 32

`endif

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes of the supported rv32i subset.
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	// alu functions; passb forwards the second operand.
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASSB
	} alu_op_e;

endpackage

// File: hdl/rv_bus_pkg.sv
package rv_bus_pkg;

	// axi response codes, exokay is never returned.
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// owner of the external port.
	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_FETCH,
		GNT_LSU
	} grant_e;

endpackage

// File: hdl/rv_fetch.sv
`include "rv_params.svh"

module rv_fetch import rv_bus_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	output logic        if_arvalid,
	output logic [31:0] if_araddr,
	input  logic        if_arready,
	input  logic        if_rvalid,
	input  logic [31:0] if_rdata,
	input  logic [1:0]  if_rresp,
	output logic        if_rready,
	input  logic        wb_valid,
	input  logic [31:0] next_pc,
	input  logic        bus_err,
	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic        inst_valid,
	output logic        inst_err
);

	typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT} fetch_state_e;

	fetch_state_e state;
	logic         started;

	assign if_arvalid = (state == F_REQ);
	assign if_araddr  = pc;
	assign if_rready  = (state == F_WAIT);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state      <= F_IDLE;
			started    <= 1'b0;
			pc         <= `RV_RESET_PC;
			inst_valid <= 1'b0;
			inst_err   <= 1'b0;
		end else begin
			started    <= 1'b1;
			inst_valid <= 1'b0;
			// any error in the retiring instruction diverts to the trap handler.
			if (wb_valid)
				pc <= bus_err ? `RV_TRAP_PC : next_pc;
			case (state)
				// the very first fetch needs no write-back to start
				F_IDLE: if (wb_valid || !started)
					state <= F_REQ;
				F_REQ: if (if_arready)
					state <= F_WAIT;
				F_WAIT: if (if_rvalid) begin
					inst_valid <= 1'b1;
					inst_err   <= (if_rresp != RESP_OKAY);
					state      <= F_IDLE;
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (if_rvalid && if_rready)
			inst <= if_rdata;
	end

endmodule

// File: hdl/rv_execute.sv
module rv_execute import rv_isa_pkg::*; (
	input  logic [31:0] pc,
	input  logic [31:0] inst,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd,
	output logic        rd_wen,
	output logic [31:0] result,
	output logic [31:0] next_pc,
	output logic        mem_ren,
	output logic        mem_wen,
	output logic [31:0] mem_addr,
	output logic [31:0] store_data
);

	opcode_e     opcode;
	alu_op_e     alu_op;
	logic [2:0]  funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic [31:0] target;
	logic        take_branch;
	logic        is_jal;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign rd     = inst[11:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// decode, unknown encodings fall through with no side effects.
	always_comb begin
		alu_op      = ALU_ADD;
		op_a        = src1;
		op_b        = src2;
		rd_wen      = 1'b0;
		mem_ren     = 1'b0;
		mem_wen     = 1'b0;
		take_branch = 1'b0;
		is_jal      = 1'b0;
		case (opcode)
			OP_LUI: begin
				alu_op = ALU_PASSB;
				op_b   = imm_u;
				rd_wen = 1'b1;
			end
			OP_IMM: begin
				op_b   = imm_i;
				rd_wen = (funct3 == 3'b000);
			end
			OP_REG: begin
				rd_wen = 1'b1;
				case (funct3)
					3'b000: alu_op = inst[30] ? ALU_SUB : ALU_ADD;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					default: rd_wen = 1'b0;
				endcase
			end
			OP_LOAD: begin
				op_b    = imm_i;
				mem_ren = (funct3 == 3'b010);
				rd_wen  = (funct3 == 3'b010);
			end
			OP_STORE: begin
				op_b    = imm_s;
				mem_wen = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				if (funct3 == 3'b000)
					take_branch = (src1 == src2);
				else if (funct3 == 3'b001)
					take_branch = (src1 != src2);
			end
			OP_JAL: begin
				// link value pc + 4 comes out of the alu.
				op_a   = pc;
				op_b   = 32'd4;
				rd_wen = 1'b1;
				is_jal = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:   alu_out = op_a - op_b;
			ALU_AND:   alu_out = op_a & op_b;
			ALU_OR:    alu_out = op_a | op_b;
			ALU_XOR:   alu_out = op_a ^ op_b;
			ALU_PASSB: alu_out = op_b;
			default:   alu_out = op_a + op_b;
		endcase
	end

	assign target     = pc + (is_jal ? imm_j : imm_b);
	assign next_pc    = (is_jal || take_branch) ? target : pc + 32'd4;
	assign result     = alu_out;
	assign mem_addr   = alu_out;
	assign store_data = src2;

endmodule

// File: hdl/rv_regfile.sv
`include "rv_params.svh"

module rv_regfile (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic [31:0] wdata,
	input  logic        wen,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [`RV_NREGS];

	// x0 is cleared by reset and never written, so it reads as zero.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NREGS; i++)
				regs[i] <= 32'd0;
		end else if (wen && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

endmodule

// File: hdl/rv_lsu.sv
module rv_lsu import rv_bus_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        inst_valid,
	input  logic        inst_err,
	input  logic        mem_ren,
	input  logic        mem_wen,
	input  logic [31:0] mem_addr,
	input  logic [31:0] store_data,
	input  logic [31:0] result,
	input  logic        rd_wen,
	output logic        ls_arvalid,
	output logic [31:0] ls_araddr,
	input  logic        ls_arready,
	input  logic        ls_rvalid,
	input  logic [31:0] ls_rdata,
	input  logic [1:0]  ls_rresp,
	output logic        ls_rready,
	output logic        ls_awvalid,
	output logic [31:0] ls_awaddr,
	input  logic        ls_awready,
	output logic        ls_wvalid,
	output logic [31:0] ls_wdata,
	output logic [3:0]  ls_wstrb,
	input  logic        ls_wready,
	input  logic        ls_bvalid,
	input  logic [1:0]  ls_bresp,
	output logic        ls_bready,
	output logic        wb_valid,
	output logic        bus_err,
	output logic [31:0] wb_data,
	output logic        wb_en
);

	typedef enum logic [2:0] {L_IDLE, L_LADDR, L_LDATA, L_STORE, L_SRESP} lsu_state_e;

	lsu_state_e  state;
	logic        aw_done;
	logic        w_done;
	logic [31:0] load_data;

	// execute outputs hold still until write-back, so payloads come straight from them.
	assign ls_arvalid = (state == L_LADDR);
	assign ls_araddr  = mem_addr;
	assign ls_rready  = (state == L_LDATA);
	assign ls_awvalid = (state == L_STORE) && !aw_done;
	assign ls_awaddr  = mem_addr;
	assign ls_wvalid  = (state == L_STORE) && !w_done;
	assign ls_wdata   = store_data;
	assign ls_wstrb   = 4'hf;
	assign ls_bready  = (state == L_SRESP);

	assign wb_data = mem_ren ? load_data : result;
	assign wb_en   = wb_valid && !bus_err && rd_wen;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state    <= L_IDLE;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
			wb_valid <= 1'b0;
			bus_err  <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			case (state)
				L_IDLE: if (inst_valid) begin
					bus_err <= inst_err;
					aw_done <= 1'b0;
					w_done  <= 1'b0;
					// a failed fetch retires at once without touching memory.
					if (!inst_err && mem_ren)
						state <= L_LADDR;
					else if (!inst_err && mem_wen)
						state <= L_STORE;
					else
						wb_valid <= 1'b1;
				end
				L_LADDR: if (ls_arready)
					state <= L_LDATA;
				L_LDATA: if (ls_rvalid) begin
					bus_err  <= bus_err || (ls_rresp != RESP_OKAY);
					wb_valid <= 1'b1;
					state    <= L_IDLE;
				end
				L_STORE: begin
					// address and data may be taken in either order.
					if (ls_awready)
						aw_done <= 1'b1;
					if (ls_wready)
						w_done <= 1'b1;
					if ((aw_done || ls_awready) && (w_done || ls_wready))
						state <= L_SRESP;
				end
				L_SRESP: if (ls_bvalid) begin
					bus_err  <= bus_err || (ls_bresp != RESP_OKAY);
					wb_valid <= 1'b1;
					state    <= L_IDLE;
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ls_rvalid && ls_rready)
			load_data <= ls_rdata;
	end

endmodule

// File: hdl/rv_bus_arbiter.sv
module rv_bus_arbiter import rv_bus_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,

	input  logic        if_arvalid,
	input  logic [31:0] if_araddr,
	output logic        if_arready,
	output logic        if_rvalid,
	output logic [31:0] if_rdata,
	output logic [1:0]  if_rresp,
	input  logic        if_rready,

	input  logic        ls_arvalid,
	input  logic [31:0] ls_araddr,
	output logic        ls_arready,
	output logic        ls_rvalid,
	output logic [31:0] ls_rdata,
	output logic [1:0]  ls_rresp,
	input  logic        ls_rready,
	input  logic        ls_awvalid,
	input  logic [31:0] ls_awaddr,
	output logic        ls_awready,
	input  logic        ls_wvalid,
	input  logic [31:0] ls_wdata,
	input  logic [3:0]  ls_wstrb,
	output logic        ls_wready,
	output logic        ls_bvalid,
	output logic [1:0]  ls_bresp,
	input  logic        ls_bready,

	output logic        mem_arvalid,
	output logic [31:0] mem_araddr,
	input  logic        mem_arready,
	input  logic        mem_rvalid,
	input  logic [31:0] mem_rdata,
	input  logic [1:0]  mem_rresp,
	output logic        mem_rready,
	output logic        mem_awvalid,
	output logic [31:0] mem_awaddr,
	input  logic        mem_awready,
	output logic        mem_wvalid,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_wstrb,
	input  logic        mem_wready,
	input  logic        mem_bvalid,
	input  logic [1:0]  mem_bresp,
	output logic        mem_bready
);

	grant_e grant;
	grant_e sel;

	// while idle a new request is routed at once, the grant follows on the next edge.
	always_comb begin
		sel = grant;
		if (grant == GNT_IDLE) begin
			if (if_arvalid)
				sel = GNT_FETCH;
			else if (ls_arvalid || ls_awvalid || ls_wvalid)
				sel = GNT_LSU;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			grant <= GNT_IDLE;
		else if (grant == GNT_IDLE)
			grant <= sel;
		else if ((mem_rvalid && mem_rready) || (mem_bvalid && mem_bready))
			grant <= GNT_IDLE;
	end

	// request side follows sel.
	assign mem_arvalid = (sel == GNT_FETCH) ? if_arvalid : (sel == GNT_LSU) && ls_arvalid;
	assign mem_araddr  = (sel == GNT_LSU) ? ls_araddr : if_araddr;
	assign mem_awvalid = (sel == GNT_LSU) && ls_awvalid;
	assign mem_awaddr  = ls_awaddr;
	assign mem_wvalid  = (sel == GNT_LSU) && ls_wvalid;
	assign mem_wdata   = ls_wdata;
	assign mem_wstrb   = ls_wstrb;
	assign if_arready  = (sel == GNT_FETCH) && mem_arready;
	assign ls_arready  = (sel == GNT_LSU) && mem_arready;
	assign ls_awready  = (sel == GNT_LSU) && mem_awready;
	assign ls_wready   = (sel == GNT_LSU) && mem_wready;

	// responses only reach the registered owner.
	assign mem_rready = (grant == GNT_FETCH) ? if_rready : (grant == GNT_LSU) && ls_rready;
	assign mem_bready = (grant == GNT_LSU) && ls_bready;
	assign if_rvalid  = (grant == GNT_FETCH) && mem_rvalid;
	assign if_rdata   = mem_rdata;
	assign if_rresp   = mem_rresp;
	assign ls_rvalid  = (grant == GNT_LSU) && mem_rvalid;
	assign ls_rdata   = mem_rdata;
	assign ls_rresp   = mem_rresp;
	assign ls_bvalid  = (grant == GNT_LSU) && mem_bvalid;
	assign ls_bresp   = mem_bresp;

endmodule

// File: hdl/rv_core.sv
module rv_core (
	input  logic        clock,
	input  logic        arst_n,

	output logic        mem_arvalid,
	output logic [31:0] mem_araddr,
	input  logic        mem_arready,
	input  logic        mem_rvalid,
	input  logic [31:0] mem_rdata,
	input  logic [1:0]  mem_rresp,
	output logic        mem_rready,

	output logic        mem_awvalid,
	output logic [31:0] mem_awaddr,
	input  logic        mem_awready,
	output logic        mem_wvalid,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_wstrb,
	input  logic        mem_wready,
	input  logic        mem_bvalid,
	input  logic [1:0]  mem_bresp,
	output logic        mem_bready
);

	logic        if_arvalid;
	logic [31:0] if_araddr;
	logic        if_arready;
	logic        if_rvalid;
	logic [31:0] if_rdata;
	logic [1:0]  if_rresp;
	logic        if_rready;

	logic        ls_arvalid;
	logic [31:0] ls_araddr;
	logic        ls_arready;
	logic        ls_rvalid;
	logic [31:0] ls_rdata;
	logic [1:0]  ls_rresp;
	logic        ls_rready;
	logic        ls_awvalid;
	logic [31:0] ls_awaddr;
	logic        ls_awready;
	logic        ls_wvalid;
	logic [31:0] ls_wdata;
	logic [3:0]  ls_wstrb;
	logic        ls_wready;
	logic        ls_bvalid;
	logic [1:0]  ls_bresp;
	logic        ls_bready;

	logic [31:0] pc;
	logic [31:0] inst;
	logic        inst_valid;
	logic        inst_err;
	logic [31:0] next_pc;
	logic        wb_valid;
	logic        bus_err;

	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic        rd_wen;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] result;
	logic        mem_ren;
	logic        mem_wen;
	logic [31:0] mem_addr;
	logic [31:0] store_data;
	logic [31:0] wb_data;
	logic        wb_en;

	rv_fetch u_fetch (
		.clock(clock),
		.arst_n(arst_n),
		.if_arvalid(if_arvalid),
		.if_araddr(if_araddr),
		.if_arready(if_arready),
		.if_rvalid(if_rvalid),
		.if_rdata(if_rdata),
		.if_rresp(if_rresp),
		.if_rready(if_rready),
		.wb_valid(wb_valid),
		.next_pc(next_pc),
		.bus_err(bus_err),
		.pc(pc),
		.inst(inst),
		.inst_valid(inst_valid),
		.inst_err(inst_err)
	);

	rv_execute u_execute (
		.pc(pc),
		.inst(inst),
		.src1(src1),
		.src2(src2),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.rd_wen(rd_wen),
		.result(result),
		.next_pc(next_pc),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.store_data(store_data)
	);

	rv_regfile u_regfile (
		.clock(clock),
		.arst_n(arst_n),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.wdata(wb_data),
		.wen(wb_en),
		.rdata1(src1),
		.rdata2(src2)
	);

	rv_lsu u_lsu (
		.clock(clock),
		.arst_n(arst_n),
		.inst_valid(inst_valid),
		.inst_err(inst_err),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.store_data(store_data),
		.result(result),
		.rd_wen(rd_wen),
		.ls_arvalid(ls_arvalid),
		.ls_araddr(ls_araddr),
		.ls_arready(ls_arready),
		.ls_rvalid(ls_rvalid),
		.ls_rdata(ls_rdata),
		.ls_rresp(ls_rresp),
		.ls_rready(ls_rready),
		.ls_awvalid(ls_awvalid),
		.ls_awaddr(ls_awaddr),
		.ls_awready(ls_awready),
		.ls_wvalid(ls_wvalid),
		.ls_wdata(ls_wdata),
		.ls_wstrb(ls_wstrb),
		.ls_wready(ls_wready),
		.ls_bvalid(ls_bvalid),
		.ls_bresp(ls_bresp),
		.ls_bready(ls_bready),
		.wb_valid(wb_valid),
		.bus_err(bus_err),
		.wb_data(wb_data),
		.wb_en(wb_en)
	);

	rv_bus_arbiter u_arbiter (
		.clock(clock),
		.arst_n(arst_n),
		.if_arvalid(if_arvalid),
		.if_araddr(if_araddr),
		.if_arready(if_arready),
		.if_rvalid(if_rvalid),
		.if_rdata(if_rdata),
		.if_rresp(if_rresp),
		.if_rready(if_rready),
		.ls_arvalid(ls_arvalid),
		.ls_araddr(ls_araddr),
		.ls_arready(ls_arready),
		.ls_rvalid(ls_rvalid),
		.ls_rdata(ls_rdata),
		.ls_rresp(ls_rresp),
		.ls_rready(ls_rready),
		.ls_awvalid(ls_awvalid),
		.ls_awaddr(ls_awaddr),
		.ls_awready(ls_awready),
		.ls_wvalid(ls_wvalid),
		.ls_wdata(ls_wdata),
		.ls_wstrb(ls_wstrb),
		.ls_wready(ls_wready),
		.ls_bvalid(ls_bvalid),
		.ls_bresp(ls_bresp),
		.ls_bready(ls_bready),
		.mem_arvalid(mem_arvalid),
		.mem_araddr(mem_araddr),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.mem_rresp(mem_rresp),
		.mem_rready(mem_rready),
		.mem_awvalid(mem_awvalid),
		.mem_awaddr(mem_awaddr),
		.mem_awready(mem_awready),
		.mem_wvalid(mem_wvalid),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_wready(mem_wready),
		.mem_bvalid(mem_bvalid),
		.mem_bresp(mem_bresp),
		.mem_bready(mem_bready)
	);

endmodule

// File: bench/rv_core_assert.sv
module rv_core_assert import rv_bus_pkg::*; (
	input logic        clock,
	input logic        arst_n,
	input grant_e      grant,
	input logic        mem_arvalid,
	input logic [31:0] mem_araddr,
	input logic        mem_arready,
	input logic        mem_awvalid,
	input logic [31:0] mem_awaddr,
	input logic        mem_awready,
	input logic        mem_wvalid,
	input logic [31:0] mem_wdata,
	input logic        mem_wready,
	input logic        if_arvalid,
	input logic        ls_arvalid,
	input logic        ls_awvalid,
	input logic        ls_wvalid,
	input logic        if_rready,
	input logic        ls_rready,
	input logic        ls_bready
);

	// a raised valid keeps its payload until ready.
	ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else $error("read address valid dropped or address changed before ready");

	aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
		mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_awaddr))
		else $error("write address valid dropped or address changed before ready");

	w_hold: assert property (@(posedge clock) disable iff (!arst_n)
		mem_wvalid && !mem_wready |=> mem_wvalid && $stable(mem_wdata))
		else $error("write data valid dropped or data changed before ready");

	// fetch waits for write-back, so only one master ever asks for the bus.
	one_grant: assert property (@(posedge clock) disable iff (!arst_n)
		!(if_arvalid && (ls_arvalid || ls_awvalid || ls_wvalid)))
		else $error("fetch and load/store requested the bus together");

	// no master may wait for a response while nobody owns the bus.
	idle_quiet: assert property (@(posedge clock) disable iff (!arst_n)
		grant == GNT_IDLE |-> !if_rready && !ls_rready && !ls_bready)
		else $error("response accepted while the grant is idle");

endmodule

bind rv_bus_arbiter rv_core_assert u_assert (
	.clock(clock),
	.arst_n(arst_n),
	.grant(grant),
	.mem_arvalid(mem_arvalid),
	.mem_araddr(mem_araddr),
	.mem_arready(mem_arready),
	.mem_awvalid(mem_awvalid),
	.mem_awaddr(mem_awaddr),
	.mem_awready(mem_awready),
	.mem_wvalid(mem_wvalid),
	.mem_wdata(mem_wdata),
	.mem_wready(mem_wready),
	.if_arvalid(if_arvalid),
	.ls_arvalid(ls_arvalid),
	.ls_awvalid(ls_awvalid),
	.ls_wvalid(ls_wvalid),
	.if_rready(if_rready),
	.ls_rready(ls_rready),
	.ls_bready(ls_bready)
);

// File: bench/rv_core_tb.sv
`include "rv_params.svh"

module rv_core_tb import rv_bus_pkg::*; ();

	localparam int MEM_WORDS  = 4096;
	localparam int PROG_LEN   = 200;
	localparam int IMG_LEN    = PROG_LEN + 15;
	localparam int IDLE_LIMIT = 200;
	localparam int STEP_LIMIT = 20000;

	logic        clock;
	logic        arst_n;
	logic        mem_arvalid;
	logic [31:0] mem_araddr;
	logic        mem_arready;
	logic        mem_rvalid;
	logic [31:0] mem_rdata;
	logic [1:0]  mem_rresp;
	logic        mem_rready;
	logic        mem_awvalid;
	logic [31:0] mem_awaddr;
	logic        mem_awready;
	logic        mem_wvalid;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic        mem_wready;
	logic        mem_bvalid;
	logic [1:0]  mem_bresp;
	logic        mem_bready;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] prog [IMG_LEN];
	logic [31:0] mreg [32];
	logic [31:0] mpc;
	logic [31:0] end_pc;
	logic [31:0] m_addr;
	logic [31:0] m_data;
	logic [4:0]  m_rd;
	int          phase;
	integer      seed;
	int          max_delay;
	int          err_budget;
	bit          run_done;
	bit          run_abort;
	bit          timed_out;
	int          n_fetch;
	int          n_load;
	int          n_store;
	int          n_trap;
	int          mismatches;
	int          total_mismatch;
	int          tests_failed;
	int          checks;

	rv_core uut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic tick();
		@(posedge clock);
		#2;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) tick();
	endtask

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [4:0] pick_reg(input int lo);
		return 5'(lo + rnd(16 - lo));
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// random program; x1 stays the data base at 0x2000.
	task automatic gen_program();
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		int         k;
		prog[0] = {20'h00002, 5'd1, 7'b0110111};
		for (int i = 1; i < PROG_LEN; i++) begin
			rd = pick_reg(2);
			ra = pick_reg(0);
			rb = (rnd(4) == 0) ? ra : pick_reg(0);
			case (rnd(7))
				0: prog[i] = {20'($random(seed)), rd, 7'b0110111};
				1: prog[i] = {12'($random(seed)), ra, 3'b000, rd, 7'b0010011};
				2: begin
					k = rnd(5);
					case (k)
						0: prog[i] = {7'h00, rb, ra, 3'b000, rd, 7'b0110011};
						1: prog[i] = {7'h20, rb, ra, 3'b000, rd, 7'b0110011};
						2: prog[i] = {7'h00, rb, ra, 3'b100, rd, 7'b0110011};
						3: prog[i] = {7'h00, rb, ra, 3'b110, rd, 7'b0110011};
						default: prog[i] = {7'h00, rb, ra, 3'b111, rd, 7'b0110011};
					endcase
				end
				3: prog[i] = {12'(rnd(16) * 4), 5'd1, 3'b010, rd, 7'b0000011};
				4: prog[i] = enc_s(12'(rnd(16) * 4), rb, 5'd1);
				5: prog[i] = enc_b((rnd(2) != 0) ? 13'd12 : 13'd8, rb, ra, 3'(rnd(2)));
				default: prog[i] = enc_j(21'd8, rd);
			endcase
		end
		// every register ends up in memory, so each result is seen by a store.
		for (int r = 2; r < 16; r++)
			prog[PROG_LEN + r - 2] = enc_s(12'(64 + (r - 2) * 4), 5'(r), 5'd1);
		prog[IMG_LEN - 1] = enc_j(21'd0, 5'd0);
	endtask

	task automatic load_program();
		int base;
		base = `RV_RESET_PC >> 2;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (32'(i) << 2) * 32'h9e37_79b1;
		// trap handler jumps back to the program start.
		mem[0] = enc_j(21'h01000, 5'd0);
		for (int i = 0; i < IMG_LEN; i++)
			mem[base + i] = prog[i];
		end_pc = `RV_RESET_PC + 32'(4 * (IMG_LEN - 1));
	endtask

	task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
		if (rd != 5'd0)
			mreg[rd] = v;
	endtask

	// isa model step for one fetched word.
	task automatic model_execute(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  rd;
		logic        taken;
		a = mreg[w[19:15]];
		b = mreg[w[24:20]];
		rd = w[11:7];
		phase = 0;
		case (w[6:0])
			7'b0110111: begin
				set_reg(rd, {w[31:12], 12'b0});
				mpc = mpc + 4;
			end
			7'b0010011: begin
				set_reg(rd, a + {{20{w[31]}}, w[31:20]});
				mpc = mpc + 4;
			end
			7'b0110011: begin
				case (w[14:12])
					3'b000: set_reg(rd, w[30] ? a - b : a + b);
					3'b100: set_reg(rd, a ^ b);
					3'b110: set_reg(rd, a | b);
					default: set_reg(rd, a & b);
				endcase
				mpc = mpc + 4;
			end
			7'b0000011: begin
				phase = 1;
				m_rd = rd;
				m_addr = a + {{20{w[31]}}, w[31:20]};
			end
			7'b0100011: begin
				phase = 2;
				m_addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				m_data = b;
			end
			7'b1100011: begin
				taken = w[12] ? (a != b) : (a == b);
				mpc = taken ? mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0} : mpc + 4;
			end
			7'b1101111: begin
				set_reg(rd, mpc + 4);
				mpc = mpc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			default: mpc = mpc + 4;
		endcase
	endtask

	function automatic bit pick_error();
		if (err_budget > 0 && rnd(25) == 0) begin
			err_budget--;
			return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			mismatches++;
			run_abort = 1'b1;
		end
	endtask

	task automatic wait_ready(input logic [31:0] addr, input bit is_read);
		int n;
		n = 0;
		while (!(is_read ? mem_rready : mem_bready) && !timed_out) begin
			tick();
			n++;
			if (n > IDLE_LIMIT) begin
				$display("timeout: response at %h was never accepted", addr);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic serve_read();
		logic [31:0] addr;
		logic [31:0] data;
		bit          is_fetch;
		bit          err;
		addr = mem_araddr;
		is_fetch = (phase != 1);
		check_value(is_fetch ? "mem_araddr (fetch)" : "mem_araddr (load)", addr,
			is_fetch ? mpc : m_addr);
		if (run_abort)
			return;
		if (is_fetch && addr == end_pc) begin
			run_done = 1'b1;
			return;
		end
		err = pick_error();
		data = mem[addr[13:2]];
		wait_cycles(rnd(max_delay + 1));
		mem_arready = 1'b1;
		tick();
		mem_arready = 1'b0;
		wait_cycles(rnd(max_delay + 1));
		mem_rvalid = 1'b1;
		mem_rdata = data;
		mem_rresp = err ? RESP_SLVERR : RESP_OKAY;
		wait_ready(addr, 1'b1);
		tick();
		mem_rvalid = 1'b0;
		mem_rresp = RESP_OKAY;
		if (err) begin
			mpc = `RV_TRAP_PC;
			phase = 0;
			n_trap++;
		end else if (is_fetch) begin
			n_fetch++;
			model_execute(data);
		end else begin
			n_load++;
			set_reg(m_rd, data);
			mpc = mpc + 4;
			phase = 0;
		end
	endtask

	task automatic serve_write();
		logic [31:0] addr;
		logic [31:0] data;
		bit          err;
		addr = mem_awaddr;
		data = mem_wdata;
		checks++;
		if (phase != 2 || !mem_wvalid) begin
			$display("unexpected store to %h while the model expects no store", addr);
			mismatches++;
			run_abort = 1'b1;
			return;
		end
		check_value("mem_awaddr", addr, m_addr);
		check_value("mem_wdata", data, m_data);
		check_value("mem_wstrb", {28'd0, mem_wstrb}, 32'hf);
		if (run_abort)
			return;
		err = pick_error();
		wait_cycles(rnd(max_delay + 1));
		mem_awready = 1'b1;
		mem_wready = 1'b1;
		tick();
		mem_awready = 1'b0;
		mem_wready = 1'b0;
		wait_cycles(rnd(max_delay + 1));
		mem_bvalid = 1'b1;
		mem_bresp = err ? RESP_SLVERR : RESP_OKAY;
		wait_ready(addr, 1'b0);
		tick();
		mem_bvalid = 1'b0;
		mem_bresp = RESP_OKAY;
		phase = 0;
		n_store++;
		if (err) begin
			mpc = `RV_TRAP_PC;
			n_trap++;
		end else begin
			mem[addr[13:2]] = data;
			mpc = mpc + 4;
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = 32'd0;
		mem_rresp = RESP_OKAY;
		mem_awready = 1'b0;
		mem_wready = 1'b0;
		mem_bvalid = 1'b0;
		mem_bresp = RESP_OKAY;
		repeat (5) @(posedge clock);
		#2 arst_n = 1'b1;
	endtask

	task automatic run_test(input int run, input string name, input int delay,
			input int errs, input bit new_prog);
		int idle;
		int steps;
		max_delay = delay;
		err_budget = errs;
		{n_fetch, n_load, n_store, n_trap, mismatches} = '0;
		run_done = 1'b0;
		run_abort = 1'b0;
		if (new_prog)
			gen_program();
		load_program();
		for (int i = 0; i < 32; i++)
			mreg[i] = 32'd0;
		mpc = `RV_RESET_PC;
		phase = 0;
		apply_reset();
		idle = 0;
		steps = 0;
		while (!run_done && !run_abort && !timed_out) begin
			tick();
			if (mem_arvalid || mem_awvalid) begin
				if (mem_arvalid)
					serve_read();
				else
					serve_write();
				idle = 0;
				steps++;
			end else if (++idle > IDLE_LIMIT) begin
				$display("timeout: no bus request for %0d cycles", IDLE_LIMIT);
				timed_out = 1'b1;
			end
			if (steps > STEP_LIMIT) begin
				$display("run %0d never reached the end of its program", run);
				mismatches++;
				run_abort = 1'b1;
			end
		end
		if (timed_out)
			mismatches++;
		total_mismatch += mismatches;
		if (mismatches != 0)
			tests_failed++;
		$display("run %0d %s: %0d fetches, %0d loads, %0d stores, %0d traps, %0d mismatches",
			run, name, n_fetch, n_load, n_store, n_trap, mismatches);
	endtask

	initial begin
		seed = 70;
		arst_n = 1'b0;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = 32'd0;
		mem_rresp = RESP_OKAY;
		mem_awready = 1'b0;
		mem_wready = 1'b0;
		mem_bvalid = 1'b0;
		mem_bresp = RESP_OKAY;
		timed_out = 1'b0;
		tests_failed = 0;
		total_mismatch = 0;
		checks = 0;
		run_test(0, "zero delay", 0, 0, 1'b1);
		if (!timed_out)
			run_test(1, "random delay", 3, 0, 1'b0);
		if (!timed_out)
			run_test(2, "bus error recovery", 3, 3, 1'b1);
		$display("tests: 3, failed: %0d, checks: %0d, mismatches: %0d",
			tests_failed, checks, total_mismatch);
		if (tests_failed == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_bus_pkg.sv
hdl/rv_fetch.sv
hdl/rv_execute.sv
hdl/rv_regfile.sv
hdl/rv_lsu.sv
hdl/rv_bus_arbiter.sv
hdl/rv_core.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator and run; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module rv_core_tb -f src.f -o rv_core_sim \
	&& ./obj_dir/rv_core_sim 2>&1 | tee sim.log \
	|| echo "build or simulation did not complete"

grep -qs "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
